//--- logic/cache_pkg.sv
package cache_pkg;

        // ------------------------------------------------------------------------
        // Line geometry.
        // ------------------------------------------------------------------------

        localparam int WORDS_PER_LINE = 4;              // Fill length in words.

        typedef logic [31:0] word_t;                    // One data word.

        // Whole line, word 0 in the low bits.
        typedef logic [WORDS_PER_LINE*32-1:0] line_t;

        // One enable per byte of the line.
        typedef logic [WORDS_PER_LINE*4-1:0] line_ben_t;

        // Word offset inside a line.
        typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_sel_t;

        // ------------------------------------------------------------------------
        // Controller states.
        // ------------------------------------------------------------------------

        typedef enum logic [2:0]
        {
                IDLE,           // Hit, write-through or pass-through.
                FILL_0,         // Line fill, word 0.
                FILL_1,         // Line fill, word 1.
                FILL_2,         // Line fill, word 2.
                FILL_3,         // Last word, line written here.
                REFRESH         // Let the new line settle before retry.
        } ctrl_state_t;

endpackage

//--- logic/ram_bus_pkg.sv
package ram_bus_pkg;

        // ------------------------------------------------------------------------
        // Load/store access, used on both the CPU and RAM side.
        // ------------------------------------------------------------------------

        typedef logic [31:0] addr_t;                    // Byte address.
        typedef logic [3:0]  ben_t;                     // Byte enables of a word.

        // One access. Held as a level until done.
        typedef struct packed
        {
                logic              rd;                  // Read request.
                logic              wr;                  // Write request.
                ben_t              ben;                 // Bytes to write.
                addr_t             addr;                // Byte address.
                cache_pkg::word_t  wdata;               // Write data.
        } mem_access_t;

        // Idle value of the bus.
        localparam mem_access_t MEM_ACCESS_IDLE = '0;

endpackage

//--- logic/line_fill_buffer.sv
module line_fill_buffer (
        input  logic                 i_clk,
        input  logic                 i_reset,
        input  logic                 i_capture,          // Store i_word.
        input  cache_pkg::word_sel_t i_sel,              // Slot to store into.
        input  cache_pkg::word_t     i_word,             // RAM read data.
        output cache_pkg::line_t     o_line
);

        import cache_pkg::*;

        // ------------------------------------------------------------------------
        // First three words of the line. The last one never lands here.
        // ------------------------------------------------------------------------

        word_t slot_q [WORDS_PER_LINE-1];

        always_ff @(posedge i_clk)
        begin
                if (i_capture)
                        slot_q[i_sel] <= i_word;
        end

        // Last word comes straight from RAM in the done cycle.
        assign o_line = {i_word, slot_q[2], slot_q[1], slot_q[0]};

        // Slot 3 has no storage, the controller writes the line instead.
        a_no_last_capture: assert property (@(posedge i_clk) disable iff (i_reset)
                i_capture |-> (i_sel != word_sel_t'(WORDS_PER_LINE - 1)));

endmodule

//--- logic/line_store.sv
module line_store #(
        parameter int LINE_COUNT = 16
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  ram_bus_pkg::addr_t    i_addr,            // Request address.
        input  logic                  i_inv,             // Invalidate all.
        input  logic                  i_cache_en,
        input  logic                  i_line_wr,         // Fill a whole line.
        input  cache_pkg::line_t      i_fill_line,
        input  logic                  i_word_wr,         // Merge hit write.
        input  cache_pkg::line_ben_t  i_word_ben,
        input  cache_pkg::line_t      i_word_line,
        output logic                  o_hit,
        output cache_pkg::line_t      o_line
);

        import cache_pkg::*;

        localparam int OFFSET_W = $clog2(WORDS_PER_LINE * 4);
        localparam int INDEX_W  = $clog2(LINE_COUNT);
        localparam int TAG_W    = 32 - OFFSET_W - INDEX_W;
        localparam int BYTES    = $bits(line_ben_t);    // Bytes per line.

        // ------------------------------------------------------------------------
        // Arrays. Only the valid bits carry reset.
        // ------------------------------------------------------------------------

        logic [TAG_W-1:0]      tag_mem  [LINE_COUNT];
        line_t                 data_mem [LINE_COUNT];
        logic [LINE_COUNT-1:0] valid_q;

        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   req_tag;

        assign index   = i_addr[OFFSET_W +: INDEX_W];
        assign req_tag = i_addr[31 -: TAG_W];

        // Reads follow the address in the same cycle.
        assign o_line = data_mem[index];
        assign o_hit  = valid_q[index] && (tag_mem[index] == req_tag);

        always_ff @(posedge i_clk)
        begin
                if (i_line_wr)
                begin
                        data_mem[index] <= i_fill_line;     // Full byte mask.
                        tag_mem[index]  <= req_tag;
                end
                else if (i_word_wr)
                begin
                        for (int b = 0; b < BYTES; b++)
                        begin
                                if (i_word_ben[b])
                                        data_mem[index][8*b +: 8] <= i_word_line[8*b +: 8];
                        end
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        valid_q <= '0;
                else if (i_inv || !i_cache_en)
                        valid_q <= '0;                      // Clear wins over a fill.
                else if (i_line_wr)
                        valid_q[index] <= 1'b1;
        end

        // Fill and hit write come from different controller states.
        a_one_writer: assert property (@(posedge i_clk) disable iff (i_reset)
                !(i_line_wr && i_word_wr));

endmodule

//--- logic/dcache_ctrl.sv
module dcache_ctrl #(
        parameter int LINE_COUNT = 16
) (
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  ram_bus_pkg::mem_access_t i_req,          // CPU request, held level.
        input  logic                     i_cache_en,
        input  logic                     i_clear,        // Back to idle.
        input  logic                     i_hit,          // From line store.
        input  cache_pkg::line_t         i_line,         // Line at request index.
        input  cache_pkg::word_t         i_ram_rd_data,
        input  logic                     i_ram_done,
        output cache_pkg::word_t         o_rd_data,
        output logic                     o_stall,
        output ram_bus_pkg::mem_access_t o_ram,          // RAM command level.
        output logic                     o_fill_capture,
        output cache_pkg::word_sel_t     o_fill_sel,
        output logic                     o_line_wr,      // Write whole fill line.
        output logic                     o_word_wr,      // Merge a hit write.
        output cache_pkg::line_ben_t     o_word_ben,
        output cache_pkg::line_t         o_word_line
);

        import cache_pkg::*;
        import ram_bus_pkg::*;

        localparam int OFFSET_W = $clog2(WORDS_PER_LINE * 4);   // Byte offset in line.
        localparam int INDEX_W  = $clog2(LINE_COUNT);

        ctrl_state_t state_q;
        ctrl_state_t state_nxt;
        word_sel_t   fill_sel;                          // Word being fetched.
        word_sel_t   req_word;                          // Word of the request.
        logic        req_active;

        assign req_active = i_req.rd || i_req.wr;
        assign req_word   = i_req.addr[OFFSET_W-1:2];

        // Read data from the line, or straight from RAM when disabled.
        assign o_rd_data = i_cache_en ? i_line[32*req_word +: 32] : i_ram_rd_data;

        // Hit write, shifted into its slot of the line.
        assign o_word_ben  = line_ben_t'(i_req.ben) << (4 * req_word);
        assign o_word_line = line_t'(i_req.wdata) << (32 * req_word);

        always_comb
        begin
                case (state_q)
                FILL_1:  fill_sel = 2'd1;
                FILL_2:  fill_sel = 2'd2;
                FILL_3:  fill_sel = 2'd3;
                default: fill_sel = 2'd0;
                endcase
        end

        // ------------------------------------------------------------------------
        // Next state and outputs.
        // ------------------------------------------------------------------------

        always_comb
        begin
                state_nxt      = state_q;
                o_stall        = 1'b0;
                o_ram          = MEM_ACCESS_IDLE;
                o_fill_capture = 1'b0;
                o_fill_sel     = fill_sel;
                o_line_wr      = 1'b0;
                o_word_wr      = 1'b0;

                case (state_q)
                IDLE:
                begin
                        if (!i_cache_en && req_active)
                        begin
                                o_ram   = i_req;                // Pass-through.
                                o_stall = !i_ram_done;
                        end
                        else if (i_req.wr)
                        begin
                                o_ram     = i_req;              // Write-through.
                                o_stall   = !i_ram_done;
                                o_word_wr = i_ram_done && i_hit; // Merge on hit only.
                        end
                        else if (i_req.rd && !i_hit)
                        begin
                                o_stall   = 1'b1;               // Miss, start the fill.
                                state_nxt = FILL_0;
                        end
                end

                FILL_0, FILL_1, FILL_2, FILL_3:
                begin
                        o_stall    = 1'b1;
                        o_ram.rd   = 1'b1;
                        o_ram.ben  = '1;
                        o_ram.addr = {i_req.addr[31:OFFSET_W], fill_sel, 2'b00};

                        if (i_ram_done)
                        begin
                                if (state_q == FILL_3)
                                begin
                                        o_line_wr = 1'b1;       // Fourth word is live.
                                        state_nxt = REFRESH;
                                end
                                else
                                begin
                                        o_fill_capture = 1'b1;
                                        state_nxt      = ctrl_state_t'(state_q + 3'd1);
                                end
                        end
                end

                REFRESH:
                begin
                        o_stall   = 1'b1;                       // Retry is a hit next.
                        state_nxt = IDLE;
                end

                default:
                begin
                        state_nxt = IDLE;
                end
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        state_q <= IDLE;
                else if (i_clear)
                        state_q <= IDLE;                        // Highest priority.
                else
                        state_q <= state_nxt;
        end

        // ------------------------------------------------------------------------
        // Checks.
        // ------------------------------------------------------------------------

        // A CPU access never reads and writes at once.
        a_ram_rd_wr: assert property (@(posedge i_clk) disable iff (i_reset)
                !(o_ram.rd && o_ram.wr));

        // The line store writes at the live index, so it must hold during a fill.
        a_fill_index: assert property (@(posedge i_clk) disable iff (i_reset || i_clear)
                (state_q != IDLE) |-> $stable(i_req.addr[OFFSET_W +: INDEX_W]));

endmodule

//--- logic/dcache_top.sv
module dcache_top #(
        parameter int LINE_COUNT = 16
) (
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  ram_bus_pkg::mem_access_t i_req,
        input  logic                     i_cache_en,
        input  logic                     i_inv,
        input  logic                     i_clear,
        output cache_pkg::word_t         o_rd_data,
        output logic                     o_stall,
        output ram_bus_pkg::mem_access_t o_ram,
        input  cache_pkg::word_t         i_ram_rd_data,
        input  logic                     i_ram_done
);

        import cache_pkg::*;

        logic      hit;
        line_t     line;                                // Line at request index.
        line_t     fill_line;                           // Assembled fill.
        logic      fill_capture;
        word_sel_t fill_sel;
        logic      line_wr;
        logic      word_wr;
        line_ben_t word_ben;
        line_t     word_line;

        // ------------------------------------------------------------------------
        // Controller, fill buffer, line store.
        // ------------------------------------------------------------------------

        dcache_ctrl #(.LINE_COUNT(LINE_COUNT)) u_ctrl (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_req          (i_req),
                .i_cache_en     (i_cache_en),
                .i_clear        (i_clear),
                .i_hit          (hit),
                .i_line         (line),
                .i_ram_rd_data  (i_ram_rd_data),
                .i_ram_done     (i_ram_done),
                .o_rd_data      (o_rd_data),
                .o_stall        (o_stall),
                .o_ram          (o_ram),
                .o_fill_capture (fill_capture),
                .o_fill_sel     (fill_sel),
                .o_line_wr      (line_wr),
                .o_word_wr      (word_wr),
                .o_word_ben     (word_ben),
                .o_word_line    (word_line)
        );

        line_fill_buffer u_fill (
                .i_clk     (i_clk),
                .i_reset   (i_reset),
                .i_capture (fill_capture),
                .i_sel     (fill_sel),
                .i_word    (i_ram_rd_data),
                .o_line    (fill_line)
        );

        line_store #(.LINE_COUNT(LINE_COUNT)) u_store (
                .i_clk       (i_clk),
                .i_reset     (i_reset),
                .i_addr      (i_req.addr),
                .i_inv       (i_inv),
                .i_cache_en  (i_cache_en),
                .i_line_wr   (line_wr),
                .i_fill_line (fill_line),
                .i_word_wr   (word_wr),
                .i_word_ben  (word_ben),
                .i_word_line (word_line),
                .o_hit       (hit),
                .o_line      (line)
        );

endmodule

//--- testbench/ram_model.sv
module ram_model (
        input  logic                     i_clk,
        input  logic                     i_reset,
        input  ram_bus_pkg::mem_access_t i_cmd,          // Command level from DUT.
        input  logic [1:0]               i_delay,        // Extra wait cycles.
        output cache_pkg::word_t         o_rd_data,
        output logic                     o_done,         // One-cycle pulse.
        output int                       o_rd_count      // Reads served.
);

        import cache_pkg::*;

        localparam int DEPTH = 4096;                    // Covers addresses below 16 KB.

        word_t       mem [DEPTH];
        logic        busy;
        logic [1:0]  wait_cnt;
        logic [11:0] widx;

        // Start-up contents hash the full word address.
        function automatic word_t init_word(input logic [29:0] waddr);
                return (32'(waddr) * 32'h9e3779b1) ^ 32'h5bd1e995;
        endfunction

        assign widx = i_cmd.addr[13:2];

        // --------------------------------------------------------------------------
        // Accept, wait, then serve and pulse done.
        // --------------------------------------------------------------------------

        always @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < DEPTH; i++)
                                mem[i] <= init_word(30'(i));
                        busy       <= 1'b0;
                        wait_cnt   <= 2'd0;
                        o_done     <= 1'b0;
                        o_rd_count <= 0;
                end
                else if (o_done)
                        o_done <= 1'b0;                 // Command is still the old one.
                else if (!busy)
                begin
                        busy     <= i_cmd.rd || i_cmd.wr;
                        wait_cnt <= i_delay;
                end
                else if (wait_cnt != 2'd0)
                        wait_cnt <= wait_cnt - 2'd1;
                else
                begin
                        busy   <= 1'b0;
                        o_done <= 1'b1;
                        if (i_cmd.rd)
                        begin
                                o_rd_data  <= mem[widx];
                                o_rd_count <= o_rd_count + 1;
                        end
                        for (int b = 0; b < 4; b++)
                                if (i_cmd.wr && i_cmd.ben[b])
                                        mem[widx][8*b +: 8] <= i_cmd.wdata[8*b +: 8];
                end
        end

endmodule

//--- testbench/tb_dcache.sv
module tb_dcache;

        import cache_pkg::*;
        import ram_bus_pkg::*;

        localparam int TIMEOUT = 100;                   // Cycles per wait.

        logic        clk;
        logic        reset;
        mem_access_t req;
        logic        cache_en;
        logic        inv;
        logic        clear;
        word_t       rd_data;
        logic        stall;
        mem_access_t ram_cmd;
        word_t       ram_rd_data;
        logic        ram_done;
        logic [1:0]  ram_delay;
        int          ram_rd_count;
        int          errors;
        int          checks;
        int          stall_cycles;                      // Stalled cycles of the last access.
        logic [31:0] rng;
        word_t       shadow [int];                      // Words written so far.
        addr_t       rd_log [$];                        // RAM read addresses.

        dcache_top #(.LINE_COUNT(16)) uut (
                .i_clk         (clk),
                .i_reset       (reset),
                .i_req         (req),
                .i_cache_en    (cache_en),
                .i_inv         (inv),
                .i_clear       (clear),
                .o_rd_data     (rd_data),
                .o_stall       (stall),
                .o_ram         (ram_cmd),
                .i_ram_rd_data (ram_rd_data),
                .i_ram_done    (ram_done)
        );

        ram_model ram (
                .i_clk      (clk),
                .i_reset    (reset),
                .i_cmd      (ram_cmd),
                .i_delay    (ram_delay),
                .o_rd_data  (ram_rd_data),
                .o_done     (ram_done),
                .o_rd_count (ram_rd_count)
        );

        initial
        begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        // --------------------------------------------------------------------------
        // Reference model.
        // --------------------------------------------------------------------------

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                s ^= s << 13;
                s ^= s >> 17;
                s ^= s << 5;
                return s;
        endfunction

        function automatic word_t pattern_word(input logic [29:0] waddr);
                return (32'(waddr) * 32'h9e3779b1) ^ 32'h5bd1e995;  // Same hash as RAM.
        endfunction

        // Expected word from the last write or the start-up pattern.
        function automatic word_t expected_word(input addr_t a);
                if (shadow.exists(int'(a[31:2])))
                        return shadow[int'(a[31:2])];
                return pattern_word(a[31:2]);
        endfunction

        function automatic word_t merge_bytes(input word_t old, input word_t wdata, input ben_t ben);
                word_t r;
                r = old;
                for (int b = 0; b < 4; b++)
                        if (ben[b])
                                r[8*b +: 8] = wdata[8*b +: 8];
                return r;
        endfunction

        task automatic pick_addr(output addr_t a);
                rng = xorshift(rng);
                a   = {18'd0, rng[13:2], 2'b00};        // Word aligned and below 16 KB.
        endtask

        // Waits for o_stall low at the falling edge.
        task automatic wait_ready();
                int n;
                n = 0;
                @(negedge clk);
                while (stall && n < TIMEOUT)
                begin
                        n++;
                        @(negedge clk);
                end
                stall_cycles = n;
                if (stall)
                begin
                        errors++;
                        $display("Timeout, o_stall stayed high at address %h", req.addr);
                        $display("Checks %0d, errors %0d", checks, errors);
                        $display(">>> FAIL");
                        $finish;
                end
        endtask

        // One CPU access that returns the number of RAM reads it caused.
        task automatic do_access(input logic is_wr, input addr_t a, input word_t wdata,
                                 input ben_t ben, output int reads);
                int start;
                @(posedge clk);
                #5;
                rng       = xorshift(rng);
                ram_delay = 2'(rng[7:0] % 8'd3);        // Done after 1 to 3 cycles.
                rd_log.delete();
                start     = ram_rd_count;
                req.rd    = !is_wr;
                req.wr    = is_wr;
                req.ben   = is_wr ? ben : 4'hf;
                req.addr  = a;
                req.wdata = wdata;
                wait_ready();
                reads = ram_rd_count - start;
                if (is_wr)
                        shadow[int'(a[31:2])] = merge_bytes(expected_word(a), wdata, ben);
                @(posedge clk);
                #5 req = MEM_ACCESS_IDLE;
        endtask

        task automatic check_fill(input addr_t a, input int reads);
                checks++;
                if (reads != WORDS_PER_LINE || rd_log.size() != WORDS_PER_LINE)
                begin
                        errors++;
                        $display("ERR ram_rd_count delta %h expected %h", reads, WORDS_PER_LINE);
                end
                for (int i = 0; i < rd_log.size(); i++)
                        if (rd_log[i] !== {a[31:4], 4'h0} + 32'(4 * i))
                        begin
                                errors++;
                                $display("ERR o_ram.addr %h expected %h", rd_log[i],
                                         {a[31:4], 4'h0} + 32'(4 * i));
                        end
        endtask

        // A hit reads no RAM and never stalls.
        task automatic check_hit(input int reads);
                checks++;
                if (reads != 0 || stall_cycles != 0)
                begin
                        errors++;
                        $display("ERR ram_rd_count delta %h o_stall cycles %h expected 0 and 0",
                                 reads, stall_cycles);
                end
        endtask

        // --------------------------------------------------------------------------
        // Compare read data where o_stall is low.
        // --------------------------------------------------------------------------

        always @(negedge clk)
        begin
                if (!reset && req.rd && !stall)
                begin
                        checks++;
                        if (rd_data !== expected_word(req.addr))
                        begin
                                errors++;
                                $display("ERR o_rd_data at %h got %h expected %h",
                                         req.addr, rd_data, expected_word(req.addr));
                        end
                end
                if (ram_cmd.rd && ram_done)
                        rd_log.push_back(ram_cmd.addr);
        end

        initial
        begin
                addr_t a;
                int    reads;
                reset     = 1'b1;
                req       = MEM_ACCESS_IDLE;
                cache_en  = 1'b1;
                inv       = 1'b0;
                clear     = 1'b0;
                ram_delay = 2'd0;
                rng       = 32'h91f20fe3;
                errors    = 0;
                checks    = 0;
                stall_cycles = 0;
                repeat (8) @(posedge clk);
                #5 reset = 1'b0;

                @(negedge clk);
                checks++;
                if (stall !== 1'b0 || ram_cmd.rd !== 1'b0 || ram_cmd.wr !== 1'b0)
                begin
                        errors++;
                        $display("ERR o_stall %h o_ram.rd %h o_ram.wr %h expected 0",
                                 stall, ram_cmd.rd, ram_cmd.wr);
                end

                pick_addr(a);
                do_access(1'b0, a, '0, '0, reads);      // Cold miss fills the line.
                check_fill(a, reads);
                do_access(1'b0, {a[31:4], a[3:2] + 2'd1, 2'b00}, '0, '0, reads);
                check_hit(reads);

                rng = xorshift(rng);
                do_access(1'b1, a, rng, 4'b0101, reads); // Partial write-through.
                do_access(1'b0, a, '0, '0, reads);
                check_hit(reads);

                @(posedge clk);
                #5 inv = 1'b1;
                @(posedge clk);
                #5 inv = 1'b0;
                do_access(1'b0, a, '0, '0, reads);      // Refill after invalidate.
                check_fill(a, reads);

                @(posedge clk);
                #5 cache_en = 1'b0;
                for (int i = 0; i < 6; i++)
                begin
                        if (i > 0)
                                pick_addr(a);           // First one reads RAM's merged word.
                        do_access(1'b0, a, '0, '0, reads);
                        checks++;
                        if (reads != 1)
                        begin
                                errors++;
                                $display("ERR ram_rd_count delta uncached %h expected 1", reads);
                        end
                end

                $display("Checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

endmodule

//--- filelist.f
logic/cache_pkg.sv
logic/ram_bus_pkg.sv
logic/line_fill_buffer.sv
logic/line_store.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/ram_model.sv
testbench/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f filelist.f -o sim_dcache
./obj_dir/sim_dcache > sim.log
cat sim.log

if grep -q '^>>> PASS$' sim.log
then
    echo "Simulation passed."
else
    echo "Simulation failed."
    exit 1
fi
